// ==== bench/program_stimulus.txt ====
// program: word count, then one instruction word per line
// checks: register count, index value pairs, then memory count, word address value pairs
00000016
24010005 // addiu r1, r0, 5
24020003 // addiu r2, r0, 3
00221821 // addu  r3, r1, r2
00622023 // subu  r4, r3, r2
0044282a // slt   r5, r2, r4
00053100 // sll   r6, r5, 4
34c70a05 // ori   r7, r6, 0x0a05
3c088001 // lui   r8, 0x8001
01074821 // addu  r9, r8, r7
2400007f // addiu r0, r0, 0x7f
ac090008 // sw    r9, 8(r0)
8c0a0008 // lw    r10, 8(r0)
0140582a // slt   r11, r10, r0  load-use
11650001 // beq   r11, r5, +1   taken
24010099 // addiu r1, r0, 0x99  skipped
14810001 // bne   r4, r1, +1    not taken
240c0033 // addiu r12, r0, 0x33
08000013 // j     19
24020099 // addiu r2, r0, 0x99  skipped
01816821 // addu  r13, r12, r1
ac0d0010 // sw    r13, 16(r0)
fc000000 // halt
0000000e
00 00000000
01 00000005 // beq marker skipped
02 00000003 // j marker skipped
03 00000008
04 00000005
05 00000001
06 00000010
07 00000a15
08 80010000
09 80010a15
0a 80010a15
0b 00000001
0c 00000033
0d 00000038
00000002
02 80010a15
04 00000038

// ==== compile.f ====
logic/mips_isa_pkg.sv
logic/pipe_ctrl_pkg.sv
logic/instruction_fetch.sv
logic/instruction_decode.sv
logic/instruction_execute.sv
logic/memory_stage.sv
logic/hazard_unit.sv
logic/pipeline.sv
bench/pipeline_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps --top-module pipeline_tb \
  -f compile.f -o pipeline_tb_sim \
  && ./obj_dir/pipeline_tb_sim \
  || { echo "simulation did not pass"; exit 1; }

exit 0

// ==== bench/pipeline_tb.sv ====
module pipeline_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int IMEM_AW     = 8;
  localparam int DMEM_AW     = 8;
  localparam int STIM_WORDS  = 1024;
  localparam int END_TIMEOUT = 400; // cycles

  logic               clk;
  logic               reset;
  logic               halt;
  logic               write_imem;
  logic [31:0]        imem_addr;
  logic [31:0]        imem_data;
  logic [4:0]         r_addr_reg;
  logic [DMEM_AW-1:0] r_addr_mem;
  logic [31:0]        r_data_reg;
  logic [31:0]        r_data_mem;
  logic               run_end;

  logic [31:0] stim [STIM_WORDS];
  int          n_prog;
  int          n_reg;
  int          n_mem;
  int          reg_base; // first register pair in stim
  int          mem_base; // first memory pair in stim

  pipeline #(
    .IMEM_AW(IMEM_AW),
    .DMEM_AW(DMEM_AW)
  ) DUT (
    .i_clk                   (clk),
    .i_reset                 (reset),
    .i_halt                  (halt),
    .i_write_instruction_mem (write_imem),
    .i_instruction_mem_addr  (imem_addr),
    .i_instruction_mem_data  (imem_data),
    .i_r_addr_registers      (r_addr_reg),
    .i_r_addr_data_mem       (r_addr_mem),
    .o_r_data_registers      (r_data_reg),
    .o_r_data_data_mem       (r_data_mem),
    .o_end                   (run_end)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
    if (actual !== expected) begin
      $display("FAIL at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_bad_stimulus(input string what);
    $display("the stimulus file cannot be used: %s", what);
    $display("TB FAILED");
    $fatal(1, "unusable stimulus file");
  endtask

  // one word per cycle while o_end stays low
  task automatic load_program();
    for (int i = 0; i < n_prog; i++) begin
      @(posedge clk);
      write_imem <= 1'b1;
      imem_addr  <= i * 4; // byte address
      imem_data  <= stim[1 + i];
      @(negedge clk);
      compare_value({31'd0, run_end}, 32'd0, "o_end during program load");
    end
    @(posedge clk);
    write_imem <= 1'b0;
  endtask

  task automatic pause_run(input int run_cycles, input int hold_cycles);
    repeat (run_cycles) @(posedge clk);
    halt <= 1'b1;
    repeat (hold_cycles) begin
      @(negedge clk);
      compare_value({31'd0, run_end}, 32'd0, "o_end while halted mid-run");
    end
    @(posedge clk);
    halt <= 1'b0;
  endtask

  task automatic wait_for_end(input int limit);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (run_end !== 1'b1) begin
      if (cycles >= limit) begin
        $display("timeout: o_end did not rise within %0d cycles", limit);
        $display("TB FAILED");
        $fatal(1, "timeout waiting for o_end");
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic scan_registers();
    for (int k = 0; k < n_reg; k++) begin
      @(posedge clk);
      r_addr_reg <= stim[reg_base + 2 * k][4:0];
      @(negedge clk); // debug read is combinational
      compare_value(r_data_reg, stim[reg_base + 2 * k + 1],
                    $sformatf("register r%0d", stim[reg_base + 2 * k]));
    end
  endtask

  task automatic scan_memory();
    for (int k = 0; k < n_mem; k++) begin
      @(posedge clk);
      r_addr_mem <= stim[mem_base + 2 * k][DMEM_AW-1:0];
      @(negedge clk);
      compare_value(r_data_mem, stim[mem_base + 2 * k + 1],
                    $sformatf("data memory word %0d", stim[mem_base + 2 * k]));
    end
  endtask

  initial begin
    reset      <= 1'b1;
    halt       <= 1'b1; // held through reset and load
    write_imem <= 1'b0;
    imem_addr  <= '0;
    imem_data  <= '0;
    r_addr_reg <= '0;
    r_addr_mem <= '0;

    $readmemh("bench/program_stimulus.txt", stim);
    n_prog = int'(stim[0]);
    if (n_prog < 1 || n_prog > 2**IMEM_AW) begin
      report_bad_stimulus("program length missing or out of range");
    end
    reg_base = 2 + n_prog;
    n_reg    = int'(stim[1 + n_prog]);
    if (n_reg < 1 || n_reg > 32) begin
      report_bad_stimulus("register check count out of range");
    end
    mem_base = reg_base + 2 * n_reg + 1;
    n_mem    = int'(stim[mem_base - 1]);
    if (n_mem < 0 || n_mem > 64) begin
      report_bad_stimulus("memory check count out of range");
    end

    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    compare_value({31'd0, run_end}, 32'd0, "o_end after reset");

    load_program();
    halt <= 1'b0; // program starts here
    pause_run(14, 6);
    wait_for_end(END_TIMEOUT);

    scan_registers();
    scan_memory();
    compare_value({31'd0, run_end}, 32'd1, "o_end held after the run");

    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== logic/pipeline.sv ====
module pipeline #(
  parameter int IMEM_AW = 8,
  parameter int DMEM_AW = 8
) (
  input  logic               i_clk,
  input  logic               i_reset,
  input  logic               i_halt,
  input  logic               i_write_instruction_mem,
  input  logic [31:0]        i_instruction_mem_addr,
  input  logic [31:0]        i_instruction_mem_data,
  input  logic [4:0]         i_r_addr_registers,
  input  logic [DMEM_AW-1:0] i_r_addr_data_mem,
  output logic [31:0]        o_r_data_registers,
  output logic [31:0]        o_r_data_data_mem,
  output logic               o_end
);

  mips_isa_pkg::instr_t instruction;
  logic [31:0] pc4, jump_addr;
  logic        jump_flag, stall, stop;

  // ID/EX
  logic [31:0] ra, rb, imm;
  logic [4:0]  rs, rt, rd, shamt;
  pipe_ctrl_pkg::alu_op_t alu_op;
  logic alu_src, reg_dst, mem_read_id, mem_write_id, reg_write_id, mem_to_reg_id, halt_id;

  // EX/MEM
  logic [31:0] alu_result, store_data;
  logic [4:0]  write_reg, write_reg_ex;
  logic reg_write_ex, mem_read_ex, mem_write_ex, mem_to_reg_ex, halt_ex;
  pipe_ctrl_pkg::fwd_sel_t fwd_rs, fwd_rt;

  // MEM/WB
  logic [31:0] mem_alu_result, wb_data;
  logic [4:0]  wb_reg;
  logic        wb_write, halt_done;

  instruction_fetch #(.IMEM_AW(IMEM_AW)) u_fetch (
    .i_clk(i_clk), .i_reset(i_reset), .i_halt(i_halt),
    .i_write_instruction_mem(i_write_instruction_mem),
    .i_instruction_mem_addr(i_instruction_mem_addr),
    .i_instruction_mem_data(i_instruction_mem_data),
    .i_jump(jump_flag), .i_jump_addr(jump_addr),
    .i_stall(stall), .i_stop(stop),
    .o_instruction(instruction), .o_pc4(pc4)
  );

  instruction_decode u_decode (
    .i_clk(i_clk), .i_reset(i_reset), .i_halt(i_halt), .i_stall(stall),
    .i_instruction(instruction), .i_pc4(pc4),
    .i_write_enable_wb(wb_write), .i_register_wb(wb_reg), .i_data_wb(wb_data),
    .i_r_addr(i_r_addr_registers), .o_r_data(o_r_data_registers),
    .o_ra(ra), .o_rb(rb), .o_rs(rs), .o_rt(rt), .o_rd(rd),
    .o_shamt(shamt), .o_imm(imm), .o_alu_op(alu_op),
    .o_alu_src(alu_src), .o_reg_dst(reg_dst),
    .o_mem_read(mem_read_id), .o_mem_write(mem_write_id),
    .o_reg_write(reg_write_id), .o_mem_to_reg(mem_to_reg_id), .o_is_halt(halt_id),
    .o_jump(jump_flag), .o_jump_addr(jump_addr), .o_stop(stop)
  );

  hazard_unit u_hazard (
    .i_instruction(instruction), .i_rs_ex(rs), .i_rt_ex(rt),
    .i_mem_read_ex(mem_read_id), .i_reg_write_ex(reg_write_id),
    .i_write_reg_ex(write_reg_ex),
    .i_write_reg_mem(write_reg), .i_reg_write_mem(reg_write_ex),
    .i_mem_read_mem(mem_read_ex),
    .i_write_reg_wb(wb_reg), .i_reg_write_wb(wb_write),
    .o_fwd_rs(fwd_rs), .o_fwd_rt(fwd_rt), .o_stall(stall)
  );

  instruction_execute u_execute (
    .i_clk(i_clk), .i_reset(i_reset), .i_halt(i_halt),
    .i_ra(ra), .i_rb(rb), .i_rs(rs), .i_rt(rt), .i_rd(rd),
    .i_shamt(shamt), .i_imm(imm), .i_alu_op(alu_op),
    .i_alu_src(alu_src), .i_reg_dst(reg_dst),
    .i_mem_read(mem_read_id), .i_mem_write(mem_write_id),
    .i_reg_write(reg_write_id), .i_mem_to_reg(mem_to_reg_id), .i_is_halt(halt_id),
    .i_fwd_rs(fwd_rs), .i_fwd_rt(fwd_rt),
    .i_mem_alu_result(mem_alu_result), .i_wb_data(wb_data),
    .o_alu_result(alu_result), .o_store_data(store_data),
    .o_write_reg(write_reg), .o_write_reg_ex(write_reg_ex),
    .o_reg_write(reg_write_ex), .o_mem_read(mem_read_ex), .o_mem_write(mem_write_ex),
    .o_mem_to_reg(mem_to_reg_ex), .o_is_halt(halt_ex)
  );

  memory_stage #(.DMEM_AW(DMEM_AW)) u_mem (
    .i_clk(i_clk), .i_reset(i_reset), .i_halt(i_halt),
    .i_alu_result(alu_result), .i_store_data(store_data), .i_write_reg(write_reg),
    .i_reg_write(reg_write_ex), .i_mem_read(mem_read_ex), .i_mem_write(mem_write_ex),
    .i_mem_to_reg(mem_to_reg_ex), .i_is_halt(halt_ex),
    .i_r_addr(i_r_addr_data_mem), .o_r_data(o_r_data_data_mem),
    .o_mem_alu_result(mem_alu_result),
    .o_wb_write(wb_write), .o_wb_reg(wb_reg), .o_wb_data(wb_data),
    .o_halt_done(halt_done)
  );

  assign o_end = halt_done; // HALT has reached MEM/WB

endmodule

// ==== logic/hazard_unit.sv ====
module hazard_unit (
  input  mips_isa_pkg::instr_t    i_instruction,
  input  logic [4:0]              i_rs_ex,
  input  logic [4:0]              i_rt_ex,
  input  logic                    i_mem_read_ex,
  input  logic                    i_reg_write_ex,
  input  logic [4:0]              i_write_reg_ex,
  input  logic [4:0]              i_write_reg_mem,
  input  logic                    i_reg_write_mem,
  input  logic                    i_mem_read_mem,
  input  logic [4:0]              i_write_reg_wb,
  input  logic                    i_reg_write_wb,
  output pipe_ctrl_pkg::fwd_sel_t o_fwd_rs,
  output pipe_ctrl_pkg::fwd_sel_t o_fwd_rt,
  output logic                    o_stall
);

  logic [4:0] rs_id, rt_id;
  logic is_branch, ex_hit, mem_hit, load_use;

  // youngest producer wins
  function automatic pipe_ctrl_pkg::fwd_sel_t fwd(input logic [4:0] src);
    if (src == 5'd0) return pipe_ctrl_pkg::FWD_NONE;
    if (i_reg_write_mem && i_write_reg_mem == src) return pipe_ctrl_pkg::FWD_MEM;
    if (i_reg_write_wb && i_write_reg_wb == src) return pipe_ctrl_pkg::FWD_WB;
    return pipe_ctrl_pkg::FWD_NONE;
  endfunction

  always_comb begin
    o_fwd_rs = fwd(i_rs_ex);
    o_fwd_rt = fwd(i_rt_ex);
  end

  assign rs_id     = i_instruction.r.rs;
  assign rt_id     = i_instruction.r.rt;
  assign is_branch = (i_instruction.i.opcode == mips_isa_pkg::OP_BEQ) ||
                     (i_instruction.i.opcode == mips_isa_pkg::OP_BNE);

  assign load_use = i_mem_read_ex && i_write_reg_ex != 5'd0 &&
                    (i_write_reg_ex == rs_id || i_write_reg_ex == rt_id);
  // branch compares in ID, so any writer short of WB has to drain first
  assign ex_hit  = i_reg_write_ex && i_write_reg_ex != 5'd0 &&
                   (i_write_reg_ex == rs_id || i_write_reg_ex == rt_id);
  assign mem_hit = (i_reg_write_mem || i_mem_read_mem) && i_write_reg_mem != 5'd0 &&
                   (i_write_reg_mem == rs_id || i_write_reg_mem == rt_id);

  assign o_stall = load_use || (is_branch && (ex_hit || mem_hit));

endmodule

// ==== logic/memory_stage.sv ====
module memory_stage #(
  parameter int DMEM_AW = 8
) (
  input  logic               i_clk,
  input  logic               i_reset,
  input  logic               i_halt,
  input  logic [31:0]        i_alu_result,
  input  logic [31:0]        i_store_data,
  input  logic [4:0]         i_write_reg,
  input  logic               i_reg_write,
  input  logic               i_mem_read,
  input  logic               i_mem_write,
  input  logic               i_mem_to_reg,
  input  logic               i_is_halt,
  input  logic [DMEM_AW-1:0] i_r_addr,
  output logic [31:0]        o_r_data,
  output logic [31:0]        o_mem_alu_result,
  output logic               o_wb_write,
  output logic [4:0]         o_wb_reg,
  output logic [31:0]        o_wb_data,
  output logic               o_halt_done
);

  logic [31:0] dmem [2**DMEM_AW];
  logic [DMEM_AW-1:0] addr;
  logic [31:0] alu_q, load_q;
  logic        mem_to_reg_q;

  assign addr             = i_alu_result[DMEM_AW+1:2]; // word only
  assign o_mem_alu_result = i_alu_result;
  assign o_r_data         = dmem[i_r_addr];

  always_ff @(posedge i_clk) begin
    if (i_mem_write && !i_halt) dmem[addr] <= i_store_data;
  end

  // MEM/WB payload
  always_ff @(posedge i_clk) begin
    if (!i_halt) begin
      alu_q    <= i_alu_result;
      o_wb_reg <= i_write_reg;
      if (i_mem_read) load_q <= dmem[addr];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_wb_write   <= 1'b0;
      mem_to_reg_q <= 1'b0;
      o_halt_done  <= 1'b0;
    end else if (!i_halt) begin
      o_wb_write   <= i_reg_write;
      mem_to_reg_q <= i_mem_to_reg;
      o_halt_done  <= o_halt_done | i_is_halt; // sticky until reset
    end
  end

  assign o_wb_data = mem_to_reg_q ? load_q : alu_q;

endmodule

// ==== logic/instruction_execute.sv ====
module instruction_execute (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic                    i_halt,
  input  logic [31:0]             i_ra,
  input  logic [31:0]             i_rb,
  input  logic [4:0]              i_rs,
  input  logic [4:0]              i_rt,
  input  logic [4:0]              i_rd,
  input  logic [4:0]              i_shamt,
  input  logic [31:0]             i_imm,
  input  pipe_ctrl_pkg::alu_op_t  i_alu_op,
  input  logic                    i_alu_src,
  input  logic                    i_reg_dst,
  input  logic                    i_mem_read,
  input  logic                    i_mem_write,
  input  logic                    i_reg_write,
  input  logic                    i_mem_to_reg,
  input  logic                    i_is_halt,
  input  pipe_ctrl_pkg::fwd_sel_t i_fwd_rs,
  input  pipe_ctrl_pkg::fwd_sel_t i_fwd_rt,
  input  logic [31:0]             i_mem_alu_result,
  input  logic [31:0]             i_wb_data,
  output logic [31:0]             o_alu_result,
  output logic [31:0]             o_store_data,
  output logic [4:0]              o_write_reg,
  output logic [4:0]              o_write_reg_ex,
  output logic                    o_reg_write,
  output logic                    o_mem_read,
  output logic                    o_mem_write,
  output logic                    o_mem_to_reg,
  output logic                    o_is_halt
);

  logic [31:0] a, b_reg, b, alu_y;

  always_comb begin
    case (i_fwd_rs)
      pipe_ctrl_pkg::FWD_MEM: a = i_mem_alu_result;
      pipe_ctrl_pkg::FWD_WB:  a = i_wb_data;
      default:                a = i_ra;
    endcase
    case (i_fwd_rt)
      pipe_ctrl_pkg::FWD_MEM: b_reg = i_mem_alu_result;
      pipe_ctrl_pkg::FWD_WB:  b_reg = i_wb_data;
      default:                b_reg = i_rb;
    endcase
  end

  assign b = i_alu_src ? i_imm : b_reg;

  always_comb begin
    case (i_alu_op)
      pipe_ctrl_pkg::ALU_SUB: alu_y = a - b;
      pipe_ctrl_pkg::ALU_AND: alu_y = a & b;
      pipe_ctrl_pkg::ALU_OR:  alu_y = a | b;
      pipe_ctrl_pkg::ALU_SLT: alu_y = {31'd0, $signed(a) < $signed(b)};
      pipe_ctrl_pkg::ALU_SLL: alu_y = b << i_shamt; // shifts rt
      pipe_ctrl_pkg::ALU_LUI: alu_y = {b[15:0], 16'h0};
      default:                alu_y = a + b;
    endcase
  end

  assign o_write_reg_ex = i_reg_dst ? i_rd : i_rt; // also seen by the hazard unit

  always_ff @(posedge i_clk) begin
    if (!i_halt) begin
      o_alu_result <= alu_y;
      o_store_data <= b_reg;
      o_write_reg  <= o_write_reg_ex;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      {o_reg_write, o_mem_read, o_mem_write, o_mem_to_reg, o_is_halt} <= '0;
    end else if (!i_halt) begin
      o_reg_write  <= i_reg_write;
      o_mem_read   <= i_mem_read;
      o_mem_write  <= i_mem_write;
      o_mem_to_reg <= i_mem_to_reg;
      o_is_halt    <= i_is_halt;
    end
  end

endmodule

// ==== logic/instruction_decode.sv ====
module instruction_decode (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  logic                   i_halt,
  input  logic                   i_stall,
  input  mips_isa_pkg::instr_t   i_instruction,
  input  logic [31:0]            i_pc4,
  input  logic                   i_write_enable_wb,
  input  logic [4:0]             i_register_wb,
  input  logic [31:0]            i_data_wb,
  input  logic [4:0]             i_r_addr,
  output logic [31:0]            o_r_data,
  output logic [31:0]            o_ra,
  output logic [31:0]            o_rb,
  output logic [4:0]             o_rs,
  output logic [4:0]             o_rt,
  output logic [4:0]             o_rd,
  output logic [4:0]             o_shamt,
  output logic [31:0]            o_imm,
  output pipe_ctrl_pkg::alu_op_t o_alu_op,
  output logic                   o_alu_src,
  output logic                   o_reg_dst,
  output logic                   o_mem_read,
  output logic                   o_mem_write,
  output logic                   o_reg_write,
  output logic                   o_mem_to_reg,
  output logic                   o_is_halt,
  output logic                   o_jump,
  output logic [31:0]            o_jump_addr,
  output logic                   o_stop
);

  logic [31:0] regs [32];
  logic        wb_we;
  logic [31:0] ra, rb, imm, br_target;
  pipe_ctrl_pkg::alu_op_t alu_op;
  logic alu_src, reg_dst, mem_read, mem_write, reg_write, mem_to_reg, is_halt;
  logic is_beq, is_bne, is_j, zero_ext;

  assign wb_we = i_write_enable_wb && !i_halt && (i_register_wb != 5'd0);

  always_ff @(posedge i_clk) begin
    if (wb_we) regs[i_register_wb] <= i_data_wb;
  end

  // write first, r0 reads zero
  function automatic logic [31:0] rf_read(input logic [4:0] addr);
    if (addr == 5'd0) return '0;
    if (wb_we && addr == i_register_wb) return i_data_wb;
    return regs[addr];
  endfunction

  always_comb begin
    ra       = rf_read(i_instruction.r.rs);
    rb       = rf_read(i_instruction.r.rt);
    o_r_data = rf_read(i_r_addr); // debug port
  end

  always_comb begin
    alu_op     = pipe_ctrl_pkg::ALU_ADD;
    {alu_src, reg_dst, mem_read, mem_write, reg_write, mem_to_reg} = '0;
    {is_halt, is_beq, is_bne, is_j, zero_ext} = '0;
    case (i_instruction.i.opcode)
      mips_isa_pkg::OP_RTYPE: begin
        reg_dst   = 1'b1;
        reg_write = 1'b1;
        case (i_instruction.r.funct)
          mips_isa_pkg::FN_ADDU: alu_op = pipe_ctrl_pkg::ALU_ADD;
          mips_isa_pkg::FN_SUBU: alu_op = pipe_ctrl_pkg::ALU_SUB;
          mips_isa_pkg::FN_AND:  alu_op = pipe_ctrl_pkg::ALU_AND;
          mips_isa_pkg::FN_OR:   alu_op = pipe_ctrl_pkg::ALU_OR;
          mips_isa_pkg::FN_SLT:  alu_op = pipe_ctrl_pkg::ALU_SLT;
          mips_isa_pkg::FN_SLL:  alu_op = pipe_ctrl_pkg::ALU_SLL;
          default:               reg_write = 1'b0; // unknown funct does nothing
        endcase
      end
      mips_isa_pkg::OP_ADDIU: {alu_src, reg_write} = 2'b11;
      mips_isa_pkg::OP_ANDI: begin
        {alu_src, reg_write, zero_ext} = 3'b111;
        alu_op = pipe_ctrl_pkg::ALU_AND;
      end
      mips_isa_pkg::OP_ORI: begin
        {alu_src, reg_write, zero_ext} = 3'b111;
        alu_op = pipe_ctrl_pkg::ALU_OR;
      end
      mips_isa_pkg::OP_LUI: begin
        {alu_src, reg_write, zero_ext} = 3'b111;
        alu_op = pipe_ctrl_pkg::ALU_LUI;
      end
      mips_isa_pkg::OP_LW:   {alu_src, mem_read, reg_write, mem_to_reg} = 4'b1111;
      mips_isa_pkg::OP_SW:   {alu_src, mem_write} = 2'b11;
      mips_isa_pkg::OP_BEQ:  is_beq = 1'b1;
      mips_isa_pkg::OP_BNE:  is_bne = 1'b1;
      mips_isa_pkg::OP_J:    is_j = 1'b1;
      mips_isa_pkg::OP_HALT: is_halt = 1'b1;
      default: ;
    endcase
  end

  assign imm = zero_ext ? {16'h0, i_instruction.i.imm16}
                        : {{16{i_instruction.i.imm16[15]}}, i_instruction.i.imm16};
  assign br_target = i_pc4 + {imm[29:0], 2'b00};

  // no branch decision while its operands are still in flight
  assign o_jump = !i_stall && (is_j || (is_beq && ra == rb) || (is_bne && ra != rb));
  assign o_jump_addr = is_j ? {i_pc4[31:28], i_instruction.r[25:0], 2'b00} : br_target;
  assign o_stop = is_halt;

  // ID/EX payload
  always_ff @(posedge i_clk) begin
    if (!i_halt) begin
      o_ra      <= ra;
      o_rb      <= rb;
      o_rs      <= i_instruction.r.rs;
      o_rt      <= i_instruction.r.rt;
      o_rd      <= i_instruction.r.rd;
      o_shamt   <= i_instruction.r.shamt;
      o_imm     <= imm;
      o_alu_op  <= alu_op;
      o_alu_src <= alu_src;
      o_reg_dst <= reg_dst;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      {o_mem_read, o_mem_write, o_reg_write, o_mem_to_reg, o_is_halt} <= '0;
    end else if (!i_halt) begin
      if (i_stall) begin
        {o_mem_read, o_mem_write, o_reg_write, o_mem_to_reg, o_is_halt} <= '0; // bubble
      end else begin
        o_mem_read   <= mem_read;
        o_mem_write  <= mem_write;
        o_reg_write  <= reg_write;
        o_mem_to_reg <= mem_to_reg;
        o_is_halt    <= is_halt;
      end
    end
  end

endmodule

// ==== logic/instruction_fetch.sv ====
module instruction_fetch #(
  parameter int IMEM_AW = 8
) (
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  logic                 i_halt,
  input  logic                 i_write_instruction_mem,
  input  logic [31:0]          i_instruction_mem_addr,
  input  logic [31:0]          i_instruction_mem_data,
  input  logic                 i_jump,
  input  logic [31:0]          i_jump_addr,
  input  logic                 i_stall,
  input  logic                 i_stop,
  output mips_isa_pkg::instr_t o_instruction,
  output logic [31:0]          o_pc4
);

  logic [31:0] imem [2**IMEM_AW];
  logic [31:0] pc;
  logic [31:0] pc_next;

  assign pc_next = pc + 32'd4;

  // load port, byte address in, word index used
  always_ff @(posedge i_clk) begin
    if (i_write_instruction_mem) begin
      imem[i_instruction_mem_addr[IMEM_AW+1:2]] <= i_instruction_mem_data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pc            <= '0;
      o_instruction <= '0; // nop
      o_pc4         <= '0;
    end else if (!i_halt) begin
      if (i_jump) begin
        pc            <= i_jump_addr;
        o_instruction <= '0; // squash the word behind the branch
      end else if (!(i_stall || i_stop)) begin
        pc            <= pc_next;
        o_instruction <= mips_isa_pkg::instr_t'(imem[pc[IMEM_AW+1:2]]);
        o_pc4         <= pc_next;
      end
    end
  end

endmodule

// ==== logic/pipe_ctrl_pkg.sv ====
package pipe_ctrl_pkg;

  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_SLT = 4'd4,
    ALU_SLL = 4'd5,
    ALU_LUI = 4'd6
  } alu_op_t;

  // where an ex operand comes from
  typedef enum logic [1:0] {
    FWD_NONE = 2'd0,
    FWD_MEM  = 2'd1,
    FWD_WB   = 2'd2
  } fwd_sel_t;

endpackage

// ==== logic/mips_isa_pkg.sv ====
package mips_isa_pkg;

  // register format, also carries the 26 bit jump target in its low bits
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm16;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_t;

  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_J     = 6'h02;
  localparam logic [5:0] OP_BEQ   = 6'h04;
  localparam logic [5:0] OP_BNE   = 6'h05;
  localparam logic [5:0] OP_ADDIU = 6'h09;
  localparam logic [5:0] OP_ANDI  = 6'h0c;
  localparam logic [5:0] OP_ORI   = 6'h0d;
  localparam logic [5:0] OP_LUI   = 6'h0f;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2b;
  localparam logic [5:0] OP_HALT  = 6'h3f; // not a real mips opcode

  localparam logic [5:0] FN_SLL  = 6'h00;
  localparam logic [5:0] FN_ADDU = 6'h21;
  localparam logic [5:0] FN_SUBU = 6'h23;
  localparam logic [5:0] FN_AND  = 6'h24;
  localparam logic [5:0] FN_OR   = 6'h25;
  localparam logic [5:0] FN_SLT  = 6'h2a;

endpackage
